// ==== Bender.yml ====
package:
  name: crpa

sources:
  - source/crpa_pkg.sv
  - source/crpa_regs.sv
  - source/crpa_capture.sv
  - source/crpa_sample_fifo.sv
  - source/crpa_combiner.sv
  - source/crpa.sv
  - target: simulation
    files:
      - verif/crpa_tb.sv

// ==== source/crpa.sv ====
`timescale 1ns/1ns
`default_nettype none

module crpa #(
    parameter int                  NUM_CH     = 4,
    parameter crpa_pkg::bus_addr_t BASE_ADDR  = 32'h1000_0000,
    parameter int                  FIFO_DEPTH = 8
) (
    input  wire                               data_in,
    input  wire                               reset,
    input  wire                               ce,
    input  wire crpa_pkg::sample_t [NUM_CH-1:0] adc_samples,
    input  wire                               wr_en,
    input  wire                               rd_en,
    input  wire crpa_pkg::bus_addr_t          addr,
    input  wire crpa_pkg::bus_data_t          wdata,
    output wire crpa_pkg::bus_data_t          rdata,
    output wire                               rd_valid,
    output wire                               out_valid,
    output wire crpa_pkg::sample_t            data_out_full,
    output wire crpa_pkg::quant_t             data_out,
    output wire                               overflow
);

    // register bank levels
    crpa_pkg::sample_t [NUM_CH-1:0] offsets;
    crpa_pkg::weight_t [NUM_CH-1:0] weights;
    crpa_pkg::shift_t               shift;
    crpa_pkg::sample_t              thresh;

    // capture -> fifo
    logic                           cap_valid;
    crpa_pkg::sample_t [NUM_CH-1:0] cap_samples;

    // fifo -> combiner
    crpa_pkg::sample_t [NUM_CH-1:0] head_samples;
    logic                           empty;
    logic                           pop;

    // map holds at most 16 channels; depth wraps as a power of two
    if (NUM_CH < 1 || NUM_CH > crpa_pkg::MAX_CH || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)
    begin : g_param_check
        $error("crpa: NUM_CH or FIFO_DEPTH out of range");
    end

    crpa_regs #(.NUM_CH(NUM_CH), .BASE_ADDR(BASE_ADDR)) u_regs (
        .data_in  (data_in),
        .reset    (reset),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .offsets  (offsets),
        .weights  (weights),
        .shift    (shift),
        .thresh   (thresh)
    );

    crpa_capture #(.NUM_CH(NUM_CH)) u_capture (
        .data_in     (data_in),
        .reset       (reset),
        .ce          (ce),
        .adc_samples (adc_samples),
        .offsets     (offsets),
        .cap_valid   (cap_valid),
        .cap_samples (cap_samples)
    );

    crpa_sample_fifo #(.NUM_CH(NUM_CH), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .data_in      (data_in),
        .reset        (reset),
        .push         (cap_valid),
        .push_samples (cap_samples),
        .pop          (pop),
        .head_samples (head_samples),
        .empty        (empty),
        .overflow     (overflow)
    );

    crpa_combiner #(.NUM_CH(NUM_CH)) u_combiner (
        .data_in       (data_in),
        .reset         (reset),
        .empty         (empty),
        .head_samples  (head_samples),
        .weights       (weights),
        .shift         (shift),
        .thresh        (thresh),
        .pop           (pop),
        .out_valid     (out_valid),
        .data_out_full (data_out_full),
        .data_out      (data_out)
    );

endmodule

`default_nettype wire

// ==== source/crpa_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module crpa_capture #(
    parameter int NUM_CH = 4
) (
    input  wire                               data_in,
    input  wire                               reset,
    input  wire                               ce,
    input  wire crpa_pkg::sample_t [NUM_CH-1:0] adc_samples,
    input  wire crpa_pkg::sample_t [NUM_CH-1:0] offsets,
    output logic                              cap_valid,
    output crpa_pkg::sample_t [NUM_CH-1:0]    cap_samples
);

    // one guard bit above the sample width
    typedef logic signed [crpa_pkg::SAMPLE_W:0] diff_t;

    diff_t             diff [NUM_CH];
    crpa_pkg::sample_t sat  [NUM_CH];

    // dc offset removal per channel
    always_comb begin
        for (int k = 0; k < NUM_CH; k++) begin
            diff[k] = diff_t'(adc_samples[k]) - diff_t'(offsets[k]);
            // clip back into sample range
            if (diff[k] > crpa_pkg::SAMPLE_MAX)
                sat[k] = crpa_pkg::sample_t'(crpa_pkg::SAMPLE_MAX);
            else if (diff[k] < crpa_pkg::SAMPLE_MIN)
                sat[k] = crpa_pkg::sample_t'(crpa_pkg::SAMPLE_MIN);
            else
                sat[k] = crpa_pkg::sample_t'(diff[k]);
        end
    end

    // strobe out, one cycle behind ce
    always_ff @(posedge data_in) begin
        if (reset)
            cap_valid <= 1'b0;
        else
            cap_valid <= ce;
    end

    // corrected set, held between strobes
    always_ff @(posedge data_in) begin
        if (ce) begin
            for (int k = 0; k < NUM_CH; k++)
                cap_samples[k] <= sat[k];
        end
    end

endmodule

`default_nettype wire

// ==== source/crpa_combiner.sv ====
`timescale 1ns/1ns
`default_nettype none

module crpa_combiner #(
    parameter int NUM_CH = 4
) (
    input  wire                               data_in,
    input  wire                               reset,
    input  wire                               empty,
    input  wire crpa_pkg::sample_t [NUM_CH-1:0] head_samples,
    input  wire crpa_pkg::weight_t [NUM_CH-1:0] weights,
    input  wire crpa_pkg::shift_t             shift,
    input  wire crpa_pkg::sample_t            thresh,
    output logic                              pop,
    output logic                              out_valid,
    output crpa_pkg::sample_t                 data_out_full,
    output crpa_pkg::quant_t                  data_out
);

    localparam int IDX_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

    // wide enough to hold |-2048|
    typedef logic signed [crpa_pkg::SAMPLE_W:0] mag_t;

    typedef enum logic [0:0] {
        ST_IDLE,
        ST_ACC
    } state_t;

    state_t                         state;
    logic [IDX_W-1:0]               idx;
    logic                           last;
    crpa_pkg::sample_t [NUM_CH-1:0] set_q;
    crpa_pkg::sample_t              cur_s;
    crpa_pkg::weight_t              cur_w;
    crpa_pkg::acc_t                 prod;
    crpa_pkg::acc_t                 acc;
    crpa_pkg::acc_t                 acc_next;
    crpa_pkg::acc_t                 res_acc;
    crpa_pkg::acc_t                 shifted;
    mag_t                           mag;

    // take a new set only when idle
    assign pop  = (state == ST_IDLE) && !empty;
    assign last = (idx == IDX_W'(NUM_CH - 1));

    // single shared multiplier
    always_comb begin
        cur_s    = set_q[idx];
        cur_w    = weights[idx];
        prod     = crpa_pkg::acc_t'(cur_s) * crpa_pkg::acc_t'(cur_w);
        // channel 0 restarts the sum
        acc_next = (idx == '0) ? prod : acc + prod;
    end

    // idle -> acc on pop, back after the last channel
    always_ff @(posedge data_in) begin
        if (reset) begin
            state     <= ST_IDLE;
            idx       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        state <= ST_ACC;
                        idx   <= '0;
                    end
                end
                ST_ACC: begin
                    if (last) begin
                        state     <= ST_IDLE;
                        idx       <= '0;
                        out_valid <= 1'b1;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // set latch, running sum, result hold
    // res_acc frees acc for the next set
    always_ff @(posedge data_in) begin
        if (pop)
            set_q <= head_samples;
        if (state == ST_ACC) begin
            acc <= acc_next;
            if (last)
                res_acc <= acc_next;
        end
    end

    // rescale, clip, then quantize
    always_comb begin
        shifted = res_acc >>> shift;
        if (shifted > crpa_pkg::SAMPLE_MAX)
            data_out_full = crpa_pkg::sample_t'(crpa_pkg::SAMPLE_MAX);
        else if (shifted < crpa_pkg::SAMPLE_MIN)
            data_out_full = crpa_pkg::sample_t'(crpa_pkg::SAMPLE_MIN);
        else
            data_out_full = crpa_pkg::sample_t'(shifted);
        // absolute value
        mag = data_out_full[crpa_pkg::SAMPLE_W-1] ? -mag_t'(data_out_full)
                                                  : mag_t'(data_out_full);
        data_out = {data_out_full[crpa_pkg::SAMPLE_W-1], (mag >= mag_t'(thresh))};
    end

    // a set takes NUM_CH+1 cycles from pop to pop
    if (NUM_CH > 1) begin : g_gap_check
        assert property (@(posedge data_in) disable iff (reset) out_valid |=> !out_valid)
            else $error("crpa_combiner: out_valid on consecutive cycles");
    end

endmodule

`default_nettype wire

// ==== source/crpa_pkg.sv ====
`default_nettype none

package crpa_pkg;

    // datapath widths
    localparam int SAMPLE_W = 12;
    localparam int WEIGHT_W = 16;
    localparam int ACC_W    = 32;
    localparam int SHIFT_W  = 5;
    localparam int BUS_W    = 32;

    // the register map has room for this many channels
    localparam int MAX_CH = 16;

    // saturation limits of a sample
    localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

    // adc sample, also the offset-corrected sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    // channel weight, fractional by convention
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic        [SHIFT_W-1:0]  shift_t;

    // register bus
    typedef logic [BUS_W-1:0] bus_addr_t;
    typedef logic [BUS_W-1:0] bus_data_t;

    // sign in bit 1, magnitude in bit 0
    typedef logic [1:0] quant_t;

    // word offsets from the base address
    // weight k at REG_WEIGHT+k, offset k at REG_OFFSET+k
    localparam bus_addr_t REG_WEIGHT = 32'd0;
    localparam bus_addr_t REG_OFFSET = 32'd16;
    localparam bus_addr_t REG_SHIFT  = 32'd32;
    localparam bus_addr_t REG_THRESH = 32'd33;

endpackage

`default_nettype wire

// ==== source/crpa_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module crpa_regs #(
    parameter int                  NUM_CH    = 4,
    parameter crpa_pkg::bus_addr_t BASE_ADDR = 32'h1000_0000
) (
    input  wire                                 data_in,
    input  wire                                 reset,
    input  wire                                 wr_en,
    input  wire                                 rd_en,
    input  wire crpa_pkg::bus_addr_t            addr,
    input  wire crpa_pkg::bus_data_t            wdata,
    output crpa_pkg::bus_data_t                 rdata,
    output logic                                rd_valid,
    output crpa_pkg::sample_t [NUM_CH-1:0]      offsets,
    output crpa_pkg::weight_t [NUM_CH-1:0]      weights,
    output crpa_pkg::shift_t                    shift,
    output crpa_pkg::sample_t                   thresh
);

    // word offset into the map, wraps high below the base
    crpa_pkg::bus_addr_t off;
    crpa_pkg::bus_data_t rd_next;

    assign off = addr - BASE_ADDR;

    // read mux, signed fields sign-extended
    always_comb begin
        rd_next = '0;
        for (int k = 0; k < NUM_CH; k++) begin
            if (off == crpa_pkg::REG_WEIGHT + k)
                rd_next = crpa_pkg::bus_data_t'(weights[k]);
            if (off == crpa_pkg::REG_OFFSET + k)
                rd_next = crpa_pkg::bus_data_t'(offsets[k]);
        end
        if (off == crpa_pkg::REG_SHIFT)
            rd_next = crpa_pkg::bus_data_t'(shift);
        if (off == crpa_pkg::REG_THRESH)
            rd_next = crpa_pkg::bus_data_t'(thresh);
    end

    // write side, data truncated to the field width
    // unmapped addresses fall through untouched
    always_ff @(posedge data_in) begin
        if (reset) begin
            weights <= '0;
            offsets <= '0;
            shift   <= '0;
            thresh  <= '0;
        end else if (wr_en) begin
            for (int k = 0; k < NUM_CH; k++) begin
                if (off == crpa_pkg::REG_WEIGHT + k)
                    weights[k] <= crpa_pkg::weight_t'(wdata);
                if (off == crpa_pkg::REG_OFFSET + k)
                    offsets[k] <= crpa_pkg::sample_t'(wdata);
            end
            if (off == crpa_pkg::REG_SHIFT)
                shift <= crpa_pkg::shift_t'(wdata);
            if (off == crpa_pkg::REG_THRESH)
                thresh <= crpa_pkg::sample_t'(wdata);
        end
    end

    // read data one cycle after rd_en
    always_ff @(posedge data_in) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rdata    <= '0;
        end else begin
            rd_valid <= rd_en;
            if (rd_en)
                rdata <= rd_next;
        end
    end

    // bus master issues one access per cycle
    assert property (@(posedge data_in) disable iff (reset) !(wr_en && rd_en))
        else $error("crpa_regs: wr_en and rd_en high together");

endmodule

`default_nettype wire

// ==== source/crpa_sample_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module crpa_sample_fifo #(
    parameter int NUM_CH     = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  wire                               data_in,
    input  wire                               reset,
    input  wire                               push,
    input  wire crpa_pkg::sample_t [NUM_CH-1:0] push_samples,
    input  wire                               pop,
    output crpa_pkg::sample_t [NUM_CH-1:0]    head_samples,
    output logic                              empty,
    output logic                              overflow
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // one entry is a whole sample set
    typedef crpa_pkg::sample_t [NUM_CH-1:0] set_t;

    set_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    // a set arriving while full is lost
    assign wr_ok = push && !full;
    assign rd_ok = pop && !empty;

    // show-ahead, head straight from storage
    assign head_samples = mem[rd_ptr];

    always_ff @(posedge data_in) begin
        if (wr_ok)
            mem[wr_ptr] <= push_samples;
    end

    // pointers, count and sticky flag
    always_ff @(posedge data_in) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_ok)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop leave count alone
            if (wr_ok && !rd_ok)
                count <= count + 1'b1;
            else if (rd_ok && !wr_ok)
                count <= count - 1'b1;
            if (push && full)
                overflow <= 1'b1;
        end
    end

    assert property (@(posedge data_in) disable iff (reset) count <= CNT_W'(FIFO_DEPTH))
        else $error("crpa_sample_fifo: count above depth");

    // combiner must only pop a visible set
    assert property (@(posedge data_in) disable iff (reset) pop |-> !empty)
        else $error("crpa_sample_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== tb.f ====
source/crpa_pkg.sv
source/crpa_regs.sv
source/crpa_capture.sv
source/crpa_sample_fifo.sv
source/crpa_combiner.sv
source/crpa.sv
verif/crpa_tb.sv

// ==== verif/crpa_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module crpa_tb;

    localparam int                  NUM_CH     = 4;
    localparam int                  FIFO_DEPTH = 8;
    localparam crpa_pkg::bus_addr_t BASE       = 32'h1000_0000;
    localparam int                  DRIVE_DLY  = 5;
    // whole run is a few hundred cycles
    localparam int                  MAX_CYCLES = 4000;
    localparam int                  BURST      = 2 * FIFO_DEPTH + 4;

    logic                           data_in;
    logic                           reset;
    logic                           ce;
    crpa_pkg::sample_t [NUM_CH-1:0] adc_samples;
    logic                           wr_en;
    logic                           rd_en;
    crpa_pkg::bus_addr_t            addr;
    crpa_pkg::bus_data_t            wdata;
    crpa_pkg::bus_data_t            rdata;
    logic                           rd_valid;
    logic                           out_valid;
    crpa_pkg::sample_t              data_out_full;
    crpa_pkg::quant_t               data_out;
    logic                           overflow;

    // register mirror
    crpa_pkg::weight_t m_w [NUM_CH];
    crpa_pkg::sample_t m_off [NUM_CH];
    crpa_pkg::shift_t  m_shift;
    crpa_pkg::sample_t m_thresh;

    // occupancy model, state as seen after the last edge
    int   m_cnt    = 0;
    int   m_busy   = 0;
    logic m_cv     = 1'b0;
    int   m_cv_res = 0;
    logic m_ov     = 1'b0;
    logic m_ovf    = 1'b0;
    int   exp_q[$];
    int   accepted = 0;
    int   outs     = 0;
    int   mag_hi   = 0;
    int   mag_lo   = 0;
    int   cycles   = 0;
    string test_name = "reset";

    crpa #(.NUM_CH(NUM_CH), .BASE_ADDR(BASE), .FIFO_DEPTH(FIFO_DEPTH)) DUT (
        .data_in       (data_in),
        .reset         (reset),
        .ce            (ce),
        .adc_samples   (adc_samples),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .addr          (addr),
        .wdata         (wdata),
        .rdata         (rdata),
        .rd_valid      (rd_valid),
        .out_valid     (out_valid),
        .data_out_full (data_out_full),
        .data_out      (data_out),
        .overflow      (overflow)
    );

    initial begin
        data_in = 1'b0;
        forever #20 data_in = ~data_in;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "run stopped at first failure");
    endtask

    always @(posedge data_in) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            fail_run("timeout: the run did not finish within the cycle limit");
    end

    // clip to the 12-bit sample range
    function automatic int clip(input int v);
        if (v > 2047)
            return 2047;
        if (v < -2048)
            return -2048;
        return v;
    endfunction

    // offset removal, weighted sum, shift, clip
    function automatic int combine(input crpa_pkg::sample_t [NUM_CH-1:0] s);
        int acc;
        acc = 0;
        for (int k = 0; k < NUM_CH; k++)
            acc += clip(int'($signed(s[k])) - int'(m_off[k])) * int'(m_w[k]);
        return clip(acc >>> m_shift);
    endfunction

    function automatic crpa_pkg::bus_data_t mirror_read(input crpa_pkg::bus_addr_t a);
        crpa_pkg::bus_addr_t o;
        o = a - BASE;
        for (int k = 0; k < NUM_CH; k++) begin
            if (o == crpa_pkg::REG_WEIGHT + k)
                return {{16{m_w[k][15]}}, m_w[k]};
            if (o == crpa_pkg::REG_OFFSET + k)
                return {{20{m_off[k][11]}}, m_off[k]};
        end
        if (o == crpa_pkg::REG_SHIFT)
            return {27'd0, m_shift};
        if (o == crpa_pkg::REG_THRESH)
            return {{20{m_thresh[11]}}, m_thresh};
        // unmapped reads as zero
        return '0;
    endfunction

    task automatic next_cycle();
        @(posedge data_in);
        #DRIVE_DLY;
    endtask

    task automatic bus_write(input crpa_pkg::bus_addr_t a, input crpa_pkg::bus_data_t d);
        crpa_pkg::bus_addr_t o;
        o = a - BASE;
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        next_cycle();
        wr_en = 1'b0;
        // mirror takes the truncated field
        for (int k = 0; k < NUM_CH; k++) begin
            if (o == crpa_pkg::REG_WEIGHT + k)
                m_w[k] = crpa_pkg::weight_t'(d);
            if (o == crpa_pkg::REG_OFFSET + k)
                m_off[k] = crpa_pkg::sample_t'(d);
        end
        if (o == crpa_pkg::REG_SHIFT)
            m_shift = crpa_pkg::shift_t'(d);
        if (o == crpa_pkg::REG_THRESH)
            m_thresh = crpa_pkg::sample_t'(d);
    endtask

    // read data is due exactly one cycle after rd_en
    task automatic read_check(input crpa_pkg::bus_addr_t a, input crpa_pkg::bus_data_t exp);
        rd_en = 1'b1;
        addr  = a;
        next_cycle();
        rd_en = 1'b0;
        assert (rd_valid)
            else fail_run($sformatf("rd_valid missing one cycle after a read of %h", a));
        assert (rdata == exp)
            else fail_run($sformatf("error %s: rdata at %h expected %h actual %h",
                                    test_name, a, exp, rdata));
    endtask

    task automatic read_all(input bit expect_zero);
        crpa_pkg::bus_addr_t a;
        for (int n = 0; n < 2 * NUM_CH + 2; n++) begin
            if (n < NUM_CH)
                a = BASE + crpa_pkg::REG_WEIGHT + n;
            else if (n < 2 * NUM_CH)
                a = BASE + crpa_pkg::REG_OFFSET + (n - NUM_CH);
            else
                a = BASE + crpa_pkg::REG_SHIFT + (n - 2 * NUM_CH);
            read_check(a, expect_zero ? '0 : mirror_read(a));
        end
    endtask

    task automatic configure(input int shift_val, input int thresh_val);
        for (int k = 0; k < NUM_CH; k++) begin
            bus_write(BASE + crpa_pkg::REG_WEIGHT + k, $urandom);
            bus_write(BASE + crpa_pkg::REG_OFFSET + k, $urandom);
        end
        bus_write(BASE + crpa_pkg::REG_SHIFT, shift_val);
        bus_write(BASE + crpa_pkg::REG_THRESH, thresh_val);
    endtask

    // one ce strobe, then idle until gap cycles have passed
    task automatic send_set(input int gap, input bit extreme);
        ce = 1'b1;
        for (int k = 0; k < NUM_CH; k++)
            adc_samples[k] = extreme ? ((k % 2 == 0) ? 12'sd2047 : -12'sd2048)
                                     : crpa_pkg::sample_t'($urandom);
        next_cycle();
        ce = 1'b0;
        repeat (gap - 1)
            next_cycle();
    endtask

    task automatic drain();
        while (m_cv || exp_q.size() != 0)
            next_cycle();
    endtask

    // checks first against the model, then step the model to the next edge
    always @(negedge data_in) begin : model
        int   res;
        int   mag;
        logic pop_now;
        logic acc_now;
        crpa_pkg::quant_t exp_qnt;
        if (reset) begin
            m_cnt  = 0;
            m_busy = 0;
            m_cv   = 1'b0;
            m_ov   = 1'b0;
            m_ovf  = 1'b0;
        end else begin
            assert (out_valid == m_ov)
                else fail_run($sformatf("error %s: out_valid expected %0d actual %0d",
                                        test_name, m_ov, out_valid));
            assert (overflow == m_ovf)
                else fail_run($sformatf("error %s: overflow expected %0d actual %0d",
                                        test_name, m_ovf, overflow));
            if (out_valid) begin
                res = exp_q.pop_front();
                outs++;
                assert (int'(data_out_full) == res)
                    else fail_run($sformatf("error %s: data_out_full expected %0d actual %0d",
                                            test_name, res, data_out_full));
                mag     = (res < 0) ? -res : res;
                exp_qnt = {res < 0, mag >= int'(m_thresh)};
                assert (data_out == exp_qnt)
                    else fail_run($sformatf("error %s: data_out expected %b actual %b",
                                            test_name, exp_qnt, data_out));
                if (exp_qnt[0])
                    mag_hi++;
                else
                    mag_lo++;
            end
            // combiner takes a set when idle, fifo drops a push while full
            pop_now = (m_busy == 0) && (m_cnt > 0);
            acc_now = m_cv && (m_cnt < FIFO_DEPTH);
            if (m_cv && !acc_now)
                m_ovf = 1'b1;
            if (acc_now) begin
                exp_q.push_back(m_cv_res);
                accepted++;
                m_cnt++;
            end
            if (pop_now)
                m_cnt--;
            m_ov = (m_busy == 1);
            if (pop_now)
                m_busy = NUM_CH;
            else if (m_busy > 0)
                m_busy--;
            m_cv = ce;
            if (ce)
                m_cv_res = combine(adc_samples);
        end
    end

    // sticky until reset
    assert property (@(posedge data_in) disable iff (reset) overflow |=> overflow)
        else fail_run("overflow fell after being set, with no reset in between");

    initial begin
        int acc_before;
        int outs_before;
        int burst_acc;
        void'($urandom(32'h308c2912));
        reset       = 1'b1;
        ce          = 1'b0;
        adc_samples = '0;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        addr        = '0;
        wdata       = '0;
        m_shift     = '0;
        m_thresh    = '0;
        for (int k = 0; k < NUM_CH; k++) begin
            m_w[k]   = '0;
            m_off[k] = '0;
        end
        repeat (2)
            @(posedge data_in);
        #DRIVE_DLY;
        reset = 1'b0;

        test_name = "reset_state";
        assert (!out_valid && !rd_valid && !overflow)
            else fail_run($sformatf("error %s: out_valid rd_valid overflow expected 000 actual %b%b%b",
                                    test_name, out_valid, rd_valid, overflow));
        read_all(1'b1);

        test_name = "reg_access";
        configure($urandom, $urandom);
        read_all(1'b0);
        // writes outside the map change nothing
        bus_write(BASE + 32'd40, $urandom);
        bus_write(BASE - 32'd1, $urandom);
        read_check(BASE + 32'd40, '0);
        read_check(BASE + NUM_CH, '0);
        read_check(32'h0, '0);
        read_all(1'b0);

        // first set of each round drives the saturation corners
        test_name = "combine";
        for (int r = 0; r < 3; r++) begin
            configure(12 + r, 100 + $urandom % 600);
            for (int n = 0; n < 8; n++)
                send_set(NUM_CH + 2, n == 0);
            drain();
        end

        test_name   = "burst";
        acc_before  = accepted;
        outs_before = outs;
        for (int n = 0; n < BURST; n++)
            send_set(1, 1'b0);
        drain();
        burst_acc = accepted - acc_before;
        assert (overflow)
            else fail_run($sformatf("error %s: overflow expected 1 actual %0d", test_name, overflow));
        assert (burst_acc > FIFO_DEPTH && burst_acc < BURST)
            else fail_run($sformatf("burst accepted %0d of %0d sets, expected some kept and some dropped",
                                    burst_acc, BURST));
        assert (outs - outs_before == burst_acc)
            else fail_run($sformatf("error %s: out_valid count expected %0d actual %0d",
                                    test_name, burst_acc, outs - outs_before));
        repeat (10)
            next_cycle();

        if (mag_hi == 0 || mag_lo == 0)
            fail_run("results never fell on both sides of the threshold");
        else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
